// File: design/tlp_stream_pkg.sv
package tlp_stream_pkg;

    // ------------------------------
    // stream widths
    // ------------------------------

    // data path of the 128-bit core
    localparam int TLP_DATA_W  = 128;
    localparam int QW_W        = 64;

    // one keep bit per dword on the user side
    localparam int KEEP_DW_W   = 4;
    // byte keep as seen by the core transmit port
    localparam int KEEP_BYTE_W = 16;

    // core receive sideband
    localparam int RX_USER_W   = 22;
    localparam int BAR_HIT_W   = 7;

    // first, last and bar hit packed together
    localparam int TLPS_USER_W = 9;

    // ------------------------------
    // core receive sideband fields
    // ------------------------------

    // start of tlp present in this beat
    localparam int RX_SOF_BIT     = 14;
    // set when the tlp starts at dword 2
    localparam int RX_SOF_QW_BIT  = 13;
    // end of tlp present in this beat
    localparam int RX_EOF_BIT     = 21;
    // two bit index of the last dword
    localparam int RX_EOF_DW_LSB  = 19;
    localparam int RX_BAR_HIT_LSB = 2;

    // ------------------------------
    // tlp stream user word
    // ------------------------------

    localparam int TLPS_FIRST_BIT = 0;
    localparam int TLPS_LAST_BIT  = 1;
    localparam int TLPS_BAR_LSB   = 2;

endpackage

// File: design/rx_tlp_realign.sv
`timescale 1ns/1ps

module rx_tlp_realign (
    input  logic                                    clk_pcie,
    input  logic                                    rst,

    // core receive stream
    input  logic [tlp_stream_pkg::TLP_DATA_W-1:0]   rx_data,
    input  logic [tlp_stream_pkg::RX_USER_W-1:0]    rx_user,
    input  logic                                    rx_valid,
    output logic                                    rx_ready,

    // realigned tlp stream, no back-pressure
    output logic [tlp_stream_pkg::TLP_DATA_W-1:0]   tlps_rx_data,
    output logic [tlp_stream_pkg::KEEP_DW_W-1:0]    tlps_rx_keep_dw,
    output logic                                    tlps_rx_first,
    output logic                                    tlps_rx_last,
    output logic [tlp_stream_pkg::BAR_HIT_W-1:0]    tlps_rx_bar_hit,
    output logic                                    tlps_rx_valid
);

    logic                                   ready_q;
    logic                                   in_valid;
    logic [tlp_stream_pkg::QW_W-1:0]        qw0;
    logic [tlp_stream_pkg::QW_W-1:0]        qw1;
    logic                                   sof;
    logic                                   sof_hi;
    logic                                   eof;
    logic [1:0]                             eof_dw;
    logic [tlp_stream_pkg::BAR_HIT_W-1:0]   bar_hit;
    logic                                   start_hi;
    logic                                   tail_split;

    // held upper quad-word and its flags
    logic                                   hold_valid;
    logic                                   hold_first;
    logic                                   hold_last;
    logic                                   hold_hi_dw;
    logic [tlp_stream_pkg::QW_W-1:0]        hold_qw;
    logic [tlp_stream_pkg::BAR_HIT_W-1:0]   hold_bar;

    logic [tlp_stream_pkg::TLP_DATA_W-1:0]  out_data;
    logic [tlp_stream_pkg::KEEP_DW_W-1:0]   out_keep;
    logic [tlp_stream_pkg::TLPS_USER_W-1:0] out_user;
    logic                                   out_valid;

    // ------------------------------
    // sideband decode
    // ------------------------------

    // beats offered while our registered ready was low are dropped
    assign in_valid = rx_valid && ready_q;

    assign qw0      = rx_data[tlp_stream_pkg::QW_W-1:0];
    assign qw1      = rx_data[tlp_stream_pkg::TLP_DATA_W-1:tlp_stream_pkg::QW_W];
    assign sof      = rx_user[tlp_stream_pkg::RX_SOF_BIT];
    assign sof_hi   = rx_user[tlp_stream_pkg::RX_SOF_QW_BIT];
    assign eof      = rx_user[tlp_stream_pkg::RX_EOF_BIT];
    assign eof_dw   = rx_user[tlp_stream_pkg::RX_EOF_DW_LSB +: 2];
    assign bar_hit  = rx_user[tlp_stream_pkg::RX_BAR_HIT_LSB +: tlp_stream_pkg::BAR_HIT_W];
    assign start_hi = sof && sof_hi;

    // final beat ending in dword 2 or 3 overflows the realigned beat
    assign tail_split = hold_valid && in_valid && eof && eof_dw[1];
    assign rx_ready   = !tail_split;

    // ------------------------------
    // output beat assembly
    // ------------------------------

    always_comb begin
        out_user  = '0;
        out_keep  = '0;
        out_data  = {qw1, qw0};
        out_valid = 1'b0;
        if (hold_valid) begin
            // held qw goes low, new lower qw goes high
            out_data = {qw0, hold_qw};
            out_user[tlp_stream_pkg::TLPS_FIRST_BIT] = hold_first;
            out_user[tlp_stream_pkg::TLPS_BAR_LSB +: tlp_stream_pkg::BAR_HIT_W] = hold_bar;
            if (in_valid) begin
                out_valid = 1'b1;
                out_user[tlp_stream_pkg::TLPS_LAST_BIT] = eof && !eof_dw[1];
                out_keep = {!eof || (eof_dw != 2'd0), 3'b111};
            end else if (hold_last) begin
                // leftover tail after the ready drop
                out_valid = 1'b1;
                out_user[tlp_stream_pkg::TLPS_LAST_BIT] = 1'b1;
                out_keep = {2'b00, hold_hi_dw, 1'b1};
            end
        end else begin
            // tlp starting at dword 2 waits for its next beat
            out_valid = in_valid && !start_hi;
            out_user[tlp_stream_pkg::TLPS_FIRST_BIT] = sof && !sof_hi;
            out_user[tlp_stream_pkg::TLPS_LAST_BIT]  = eof;
            out_user[tlp_stream_pkg::TLPS_BAR_LSB +: tlp_stream_pkg::BAR_HIT_W] = bar_hit;
            out_keep[0] = in_valid;
            out_keep[1] = !eof || (eof_dw != 2'd0);
            out_keep[2] = !eof || eof_dw[1];
            out_keep[3] = !eof || (eof_dw == 2'd3);
        end
    end

    // ------------------------------
    // hold register
    // ------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            ready_q    <= 1'b1;
            hold_valid <= 1'b0;
        end else begin
            ready_q <= rx_ready;
            if (in_valid) begin
                // keep holding until the tlp ends inside the lower qw
                hold_valid <= hold_valid ? (!eof || eof_dw[1]) : start_hi;
            end else if (hold_last) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (in_valid) begin
            hold_qw    <= qw1;
            hold_bar   <= bar_hit;
            hold_first <= start_hi;
            hold_last  <= eof;
            hold_hi_dw <= !eof || eof_dw[0];
        end
    end

    assign tlps_rx_data    = out_data;
    assign tlps_rx_keep_dw = out_keep;
    assign tlps_rx_first   = out_user[tlp_stream_pkg::TLPS_FIRST_BIT];
    assign tlps_rx_last    = out_user[tlp_stream_pkg::TLPS_LAST_BIT];
    assign tlps_rx_bar_hit = out_user[tlp_stream_pkg::TLPS_BAR_LSB +: tlp_stream_pkg::BAR_HIT_W];
    assign tlps_rx_valid   = out_valid;

endmodule

// File: design/tx_tlp_skid.sv
`timescale 1ns/1ps

module tx_tlp_skid (
    input  logic                                    clk_pcie,
    input  logic                                    rst,

    // upstream side
    input  logic [tlp_stream_pkg::TLP_DATA_W-1:0]   in_data,
    input  logic [tlp_stream_pkg::KEEP_DW_W-1:0]    in_keep_dw,
    input  logic                                    in_last,
    input  logic                                    in_valid,
    output logic                                    in_ready,

    // downstream side
    output logic [tlp_stream_pkg::TLP_DATA_W-1:0]   out_data,
    output logic [tlp_stream_pkg::KEEP_DW_W-1:0]    out_keep_dw,
    output logic                                    out_last,
    output logic                                    out_valid,
    input  logic                                    out_ready
);

    logic                                   hold_valid;
    logic [tlp_stream_pkg::TLP_DATA_W-1:0]  hold_data;
    logic [tlp_stream_pkg::KEEP_DW_W-1:0]   hold_keep_dw;
    logic                                   hold_last;
    logic                                   capture;

    // ------------------------------
    // bypass path
    // ------------------------------

    // accept whenever the skid entry is free
    assign in_ready = !hold_valid;

    // beat offered to a stalled port gets parked
    assign capture = in_valid && !hold_valid && !out_ready;

    // held beat always leaves first
    assign out_valid   = hold_valid || in_valid;
    assign out_data    = hold_valid ? hold_data    : in_data;
    assign out_keep_dw = hold_valid ? hold_keep_dw : in_keep_dw;
    assign out_last    = hold_valid ? hold_last    : in_last;

    // ------------------------------
    // skid entry
    // ------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (capture) begin
            hold_valid <= 1'b1;
        end else if (hold_valid && out_ready) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (capture) begin
            hold_data    <= in_data;
            hold_keep_dw <= in_keep_dw;
            hold_last    <= in_last;
        end
    end

endmodule

// File: design/link_led_blink.sv
`timescale 1ns/1ps

module link_led_blink #(
    parameter int BLINK_BIT = 25
) (
    input  logic clk_pcie,
    input  logic rst,
    input  logic link_up,
    output logic led_state
);

    // free running heartbeat
    logic [BLINK_BIT:0] beat_cnt;

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // solid on with link, blinking without
    assign led_state = link_up || beat_cnt[BLINK_BIT];

endmodule

// File: design/pcie_tlp_adapter.sv
`timescale 1ns/1ps

module pcie_tlp_adapter #(
    parameter int BLINK_BIT = 25
) (
    input  logic                                    clk_pcie,
    input  logic                                    rst,

    // core receive stream
    input  logic [tlp_stream_pkg::TLP_DATA_W-1:0]   rx_data,
    input  logic [tlp_stream_pkg::RX_USER_W-1:0]    rx_user,
    input  logic                                    rx_valid,
    output logic                                    rx_ready,

    // realigned receive tlp stream
    output logic [tlp_stream_pkg::TLP_DATA_W-1:0]   tlps_rx_data,
    output logic [tlp_stream_pkg::KEEP_DW_W-1:0]    tlps_rx_keep_dw,
    output logic                                    tlps_rx_first,
    output logic                                    tlps_rx_last,
    output logic [tlp_stream_pkg::BAR_HIT_W-1:0]    tlps_rx_bar_hit,
    output logic                                    tlps_rx_valid,

    // user transmit tlp stream
    input  logic [tlp_stream_pkg::TLP_DATA_W-1:0]   tlps_tx_data,
    input  logic [tlp_stream_pkg::KEEP_DW_W-1:0]    tlps_tx_keep_dw,
    input  logic                                    tlps_tx_last,
    input  logic                                    tlps_tx_valid,
    output logic                                    tlps_tx_ready,

    // core transmit port
    output logic [tlp_stream_pkg::TLP_DATA_W-1:0]   tx_data,
    output logic [tlp_stream_pkg::KEEP_BYTE_W-1:0]  tx_keep,
    output logic                                    tx_last,
    output logic                                    tx_valid,
    input  logic                                    tx_ready,

    input  logic                                    link_up,
    output logic                                    led_state
);

    localparam int BYTES_PER_DW = tlp_stream_pkg::KEEP_BYTE_W / tlp_stream_pkg::KEEP_DW_W;

    logic [tlp_stream_pkg::KEEP_DW_W-1:0] tx_keep_dw;

    // ------------------------------
    // receive path
    // ------------------------------

    rx_tlp_realign u_rx_tlp_realign (
        .clk_pcie        (clk_pcie),
        .rst             (rst),
        .rx_data         (rx_data),
        .rx_user         (rx_user),
        .rx_valid        (rx_valid),
        .rx_ready        (rx_ready),
        .tlps_rx_data    (tlps_rx_data),
        .tlps_rx_keep_dw (tlps_rx_keep_dw),
        .tlps_rx_first   (tlps_rx_first),
        .tlps_rx_last    (tlps_rx_last),
        .tlps_rx_bar_hit (tlps_rx_bar_hit),
        .tlps_rx_valid   (tlps_rx_valid)
    );

    // ------------------------------
    // transmit path
    // ------------------------------

    tx_tlp_skid u_tx_tlp_skid (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .in_data     (tlps_tx_data),
        .in_keep_dw  (tlps_tx_keep_dw),
        .in_last     (tlps_tx_last),
        .in_valid    (tlps_tx_valid),
        .in_ready    (tlps_tx_ready),
        .out_data    (tx_data),
        .out_keep_dw (tx_keep_dw),
        .out_last    (tx_last),
        .out_valid   (tx_valid),
        .out_ready   (tx_ready)
    );

    // dword keep to byte keep for the core
    for (genvar i = 0; i < tlp_stream_pkg::KEEP_DW_W; i++) begin : g_keep
        assign tx_keep[i*BYTES_PER_DW +: BYTES_PER_DW] = {BYTES_PER_DW{tx_keep_dw[i]}};
    end

    // ------------------------------
    // status led
    // ------------------------------

    link_led_blink #(
        .BLINK_BIT (BLINK_BIT)
    ) u_link_led_blink (
        .clk_pcie  (clk_pcie),
        .rst       (rst),
        .link_up   (link_up),
        .led_state (led_state)
    );

endmodule

// File: dv/tlp_checker.sv
`timescale 1ns/1ps

module tlp_checker (
    input logic                                   clk_pcie,
    input logic                                   rst,
    input logic                                   rx_ready,
    input logic [tlp_stream_pkg::TLP_DATA_W-1:0]  tlps_rx_data,
    input logic [tlp_stream_pkg::KEEP_DW_W-1:0]   tlps_rx_keep_dw,
    input logic                                   tlps_rx_first,
    input logic                                   tlps_rx_last,
    input logic [tlp_stream_pkg::BAR_HIT_W-1:0]   tlps_rx_bar_hit,
    input logic                                   tlps_rx_valid,
    input logic                                   tlps_tx_valid,
    input logic [tlp_stream_pkg::TLP_DATA_W-1:0]  tx_data,
    input logic [tlp_stream_pkg::KEEP_BYTE_W-1:0] tx_keep,
    input logic                                   tx_last,
    input logic                                   tx_valid,
    input logic                                   tx_ready,
    input logic                                   link_up,
    input logic                                   led_state
);

    typedef struct packed {
        logic [tlp_stream_pkg::TLP_DATA_W-1:0] data;
        logic [tlp_stream_pkg::KEEP_DW_W-1:0]  keep;
        logic                                  first;
        logic                                  last;
        logic [tlp_stream_pkg::BAR_HIT_W-1:0]  bar;
    } rx_beat_t;

    typedef struct packed {
        logic [tlp_stream_pkg::TLP_DATA_W-1:0] data;
        logic [tlp_stream_pkg::KEEP_DW_W-1:0]  keep;
        logic                                  last;
    } tx_beat_t;

    rx_beat_t rx_exp_q[$];
    tx_beat_t tx_exp_q[$];
    rx_beat_t rx_cur;
    tx_beat_t tx_cur;
    int       rx_errors = 0;
    int       tx_errors = 0;
    int       led_errors = 0;
    int       reset_errors = 0;
    int       rx_beats = 0;
    int       tx_beats = 0;
    int       led_cycles = 0;
    logic     was_rst = 1'b1;
    logic     exp_led;

    // ------------------------------
    // queue access from the testbench
    // ------------------------------

    task automatic expect_rx_beat(input logic [127:0] data, input logic [3:0] keep,
                                  input logic first, input logic last, input logic [6:0] bar);
        rx_beat_t beat;
        beat.data  = data;
        beat.keep  = keep;
        beat.first = first;
        beat.last  = last;
        beat.bar   = bar;
        rx_exp_q.push_back(beat);
    endtask

    task automatic expect_tx_beat(input logic [127:0] data, input logic [3:0] keep,
                                  input logic last);
        tx_beat_t beat;
        beat.data = data;
        beat.keep = keep;
        beat.last = last;
        tx_exp_q.push_back(beat);
    endtask

    function automatic int pending_beats();
        return rx_exp_q.size() + tx_exp_q.size();
    endfunction

    function automatic int error_total();
        return rx_errors + tx_errors + led_errors + reset_errors;
    endfunction

    task automatic print_summary(input int timeouts);
        $display({"summary: rx beats %0d, tx beats %0d, ",
                  "errors rx %0d tx %0d led %0d reset %0d, timeouts %0d"},
                 rx_beats, tx_beats, rx_errors, tx_errors, led_errors, reset_errors, timeouts);
    endtask

    // ------------------------------
    // helpers
    // ------------------------------

    function automatic int value_mismatch(input string name, input logic [127:0] got,
                                          input logic [127:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %0h expected %0h at %0t", name, got, exp, $time);
            return 1;
        end
        return 0;
    endfunction

    // dwords outside the keep carry no meaning
    function automatic logic [127:0] dword_mask(input logic [3:0] keep);
        logic [127:0] mask;
        mask = '0;
        for (int d = 0; d < 4; d++) begin
            if (keep[d]) begin
                mask[d*32 +: 32] = 32'hffff_ffff;
            end
        end
        return mask;
    endfunction

    function automatic logic [15:0] byte_keep(input logic [3:0] keep);
        logic [15:0] bytes;
        bytes = '0;
        for (int d = 0; d < 4; d++) begin
            bytes[d*4 +: 4] = {4{keep[d]}};
        end
        return bytes;
    endfunction

    // ------------------------------
    // comparisons sampled mid cycle
    // ------------------------------

    always @(negedge clk_pcie) begin
        if (!rst && tlps_rx_valid) begin
            if (rx_exp_q.size() == 0) begin
                $display("receive beat came out with no TLP pending at %0t", $time);
                rx_errors++;
            end else begin
                rx_cur = rx_exp_q.pop_front();
                rx_beats++;
                rx_errors += value_mismatch("tlps_rx_data", tlps_rx_data & dword_mask(rx_cur.keep),
                                            rx_cur.data & dword_mask(rx_cur.keep));
                rx_errors += value_mismatch("tlps_rx_keep_dw", 128'(tlps_rx_keep_dw),
                                            128'(rx_cur.keep));
                rx_errors += value_mismatch("tlps_rx_first", 128'(tlps_rx_first),
                                            128'(rx_cur.first));
                rx_errors += value_mismatch("tlps_rx_last", 128'(tlps_rx_last),
                                            128'(rx_cur.last));
                rx_errors += value_mismatch("tlps_rx_bar_hit", 128'(tlps_rx_bar_hit),
                                            128'(rx_cur.bar));
            end
        end
    end

    always @(negedge clk_pcie) begin
        if (!rst && tx_valid && tx_ready) begin
            if (tx_exp_q.size() == 0) begin
                $display("transmit beat left the DUT with none offered at %0t", $time);
                tx_errors++;
            end else begin
                tx_cur = tx_exp_q.pop_front();
                tx_beats++;
                tx_errors += value_mismatch("tx_data", tx_data, tx_cur.data);
                tx_errors += value_mismatch("tx_last", 128'(tx_last), 128'(tx_cur.last));
                tx_errors += value_mismatch("tx_keep", 128'(tx_keep),
                                            128'(byte_keep(tx_cur.keep)));
            end
        end
    end

    always @(negedge clk_pcie) begin
        if (rst) begin
            led_cycles = 0;
        end else begin
            if (was_rst) begin
                // idle state right after reset release
                reset_errors += value_mismatch("tlps_rx_valid", 128'(tlps_rx_valid), 128'(1'b0));
                reset_errors += value_mismatch("rx_ready", 128'(rx_ready), 128'(1'b1));
                if (!tlps_tx_valid) begin
                    reset_errors += value_mismatch("tx_valid", 128'(tx_valid), 128'(1'b0));
                end
            end
            exp_led = link_up ? 1'b1 : led_cycles[4];
            led_errors += value_mismatch("led_state", 128'(led_state), 128'(exp_led));
            led_cycles++;
        end
        was_rst = rst;
    end

endmodule

// File: dv/tb_pcie_tlp_adapter.sv
`timescale 1ns/1ps

module tb_pcie_tlp_adapter;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_TLPS       = 80;
    localparam int NUM_TX_BEATS   = 200;

    logic                                   clk_pcie;
    logic                                   rst;
    logic [tlp_stream_pkg::TLP_DATA_W-1:0]  rx_data;
    logic [tlp_stream_pkg::RX_USER_W-1:0]   rx_user;
    logic                                   rx_valid;
    logic                                   rx_ready;
    logic [tlp_stream_pkg::TLP_DATA_W-1:0]  tlps_rx_data;
    logic [tlp_stream_pkg::KEEP_DW_W-1:0]   tlps_rx_keep_dw;
    logic                                   tlps_rx_first;
    logic                                   tlps_rx_last;
    logic [tlp_stream_pkg::BAR_HIT_W-1:0]   tlps_rx_bar_hit;
    logic                                   tlps_rx_valid;
    logic [tlp_stream_pkg::TLP_DATA_W-1:0]  tlps_tx_data;
    logic [tlp_stream_pkg::KEEP_DW_W-1:0]   tlps_tx_keep_dw;
    logic                                   tlps_tx_last;
    logic                                   tlps_tx_valid;
    logic                                   tlps_tx_ready;
    logic [tlp_stream_pkg::TLP_DATA_W-1:0]  tx_data;
    logic [tlp_stream_pkg::KEEP_BYTE_W-1:0] tx_keep;
    logic                                   tx_last;
    logic                                   tx_valid;
    logic                                   tx_ready;
    logic                                   link_up;
    logic                                   led_state;
    logic                                   stim_done;
    logic                                   abort;
    int                                     timeouts;
    int                                     waited;

    pcie_tlp_adapter #(
        .BLINK_BIT (4)
    ) u_pcie_tlp_adapter (
        .clk_pcie        (clk_pcie),
        .rst             (rst),
        .rx_data         (rx_data),
        .rx_user         (rx_user),
        .rx_valid        (rx_valid),
        .rx_ready        (rx_ready),
        .tlps_rx_data    (tlps_rx_data),
        .tlps_rx_keep_dw (tlps_rx_keep_dw),
        .tlps_rx_first   (tlps_rx_first),
        .tlps_rx_last    (tlps_rx_last),
        .tlps_rx_bar_hit (tlps_rx_bar_hit),
        .tlps_rx_valid   (tlps_rx_valid),
        .tlps_tx_data    (tlps_tx_data),
        .tlps_tx_keep_dw (tlps_tx_keep_dw),
        .tlps_tx_last    (tlps_tx_last),
        .tlps_tx_valid   (tlps_tx_valid),
        .tlps_tx_ready   (tlps_tx_ready),
        .tx_data         (tx_data),
        .tx_keep         (tx_keep),
        .tx_last         (tx_last),
        .tx_valid        (tx_valid),
        .tx_ready        (tx_ready),
        .link_up         (link_up),
        .led_state       (led_state)
    );

    tlp_checker u_tlp_checker (
        .clk_pcie        (clk_pcie),
        .rst             (rst),
        .rx_ready        (rx_ready),
        .tlps_rx_data    (tlps_rx_data),
        .tlps_rx_keep_dw (tlps_rx_keep_dw),
        .tlps_rx_first   (tlps_rx_first),
        .tlps_rx_last    (tlps_rx_last),
        .tlps_rx_bar_hit (tlps_rx_bar_hit),
        .tlps_rx_valid   (tlps_rx_valid),
        .tlps_tx_valid   (tlps_tx_valid),
        .tx_data         (tx_data),
        .tx_keep         (tx_keep),
        .tx_last         (tx_last),
        .tx_valid        (tx_valid),
        .tx_ready        (tx_ready),
        .link_up         (link_up),
        .led_state       (led_state)
    );

    always #50 clk_pcie = ~clk_pcie;

    // ------------------------------
    // reference model
    // ------------------------------

    // beat idx of a tlp of len dwords, packed from dword 0
    function automatic void tlp_ref_beat(input logic [31:0] dws [12], input int len,
                                         input int idx, output logic [127:0] data,
                                         output logic [3:0] keep, output logic first,
                                         output logic last);
        data = '0;
        keep = '0;
        for (int d = 0; d < 4; d++) begin
            if (idx * 4 + d < len) begin
                data[d*32 +: 32] = dws[idx*4 + d];
                keep[d]          = 1'b1;
            end
        end
        first = (idx == 0);
        last  = ((idx + 1) * 4 >= len);
    endfunction

    // ------------------------------
    // core receive model
    // ------------------------------

    task automatic next_cycle();
        @(posedge clk_pcie);
        #1;
    endtask

    task automatic drive_rx_beat(input logic [127:0] data, input logic [21:0] user);
        int   wait_cnt;
        logic taken;
        rx_data  = data;
        rx_user  = user;
        rx_valid = 1'b1;
        wait_cnt = 0;
        taken    = 1'b0;
        while (!taken && !abort) begin
            @(negedge clk_pcie);
            taken = rx_ready;
            next_cycle();
            wait_cnt++;
            if (!taken && wait_cnt >= TIMEOUT_CYCLES) begin
                $display("timeout: rx_ready stayed low for %0d cycles", wait_cnt);
                timeouts++;
                abort = 1'b1;
            end
        end
    endtask

    task automatic send_rx_tlp();
        logic [31:0]  dws [12];
        logic [6:0]   bar;
        logic [127:0] data;
        logic [21:0]  user;
        logic [127:0] exp_data;
        logic [3:0]   exp_keep;
        logic         exp_first;
        logic         exp_last;
        int           len;
        int           start;
        int           n_in;
        int           pos;
        len   = 3 + $urandom_range(9);
        start = ($urandom_range(1) == 1) ? 2 : 0;
        bar   = 7'($urandom());
        for (int k = 0; k < 12; k++) begin
            dws[k] = $urandom();
        end
        // expected beats go in before the first input beat
        for (int b = 0; b < (len + 3) / 4; b++) begin
            tlp_ref_beat(dws, len, b, exp_data, exp_keep, exp_first, exp_last);
            u_tlp_checker.expect_rx_beat(exp_data, exp_keep, exp_first, exp_last, bar);
        end
        n_in = (start + len + 3) / 4;
        for (int i = 0; i < n_in; i++) begin
            if (i > 0 && $urandom_range(3) == 0) begin
                rx_valid = 1'b0;
                next_cycle();
            end
            for (int d = 0; d < 4; d++) begin
                pos              = i * 4 + d - start;
                data[d*32 +: 32] = (pos >= 0 && pos < len) ? dws[pos] : $urandom();
            end
            user = '0;
            user[tlp_stream_pkg::RX_SOF_BIT]    = (i == 0);
            user[tlp_stream_pkg::RX_SOF_QW_BIT] = (i == 0) && (start == 2);
            user[tlp_stream_pkg::RX_EOF_BIT]    = (i == n_in - 1);
            user[tlp_stream_pkg::RX_EOF_DW_LSB +: 2]  = 2'(start + len - 1);
            user[tlp_stream_pkg::RX_BAR_HIT_LSB +: 7] = bar;
            drive_rx_beat(data, user);
        end
        rx_valid = 1'b0;
        repeat ($urandom_range(2)) next_cycle();
    endtask

    // ------------------------------
    // transmit side models
    // ------------------------------

    task automatic send_tx_beat();
        int   wait_cnt;
        logic taken;
        tlps_tx_data    = {$urandom(), $urandom(), $urandom(), $urandom()};
        tlps_tx_keep_dw = 4'($urandom());
        tlps_tx_last    = 1'($urandom());
        tlps_tx_valid   = 1'b1;
        // an offered beat is always held until taken
        u_tlp_checker.expect_tx_beat(tlps_tx_data, tlps_tx_keep_dw, tlps_tx_last);
        wait_cnt = 0;
        taken    = 1'b0;
        while (!taken && !abort) begin
            @(negedge clk_pcie);
            taken = tlps_tx_ready;
            next_cycle();
            wait_cnt++;
            if (!taken && wait_cnt >= TIMEOUT_CYCLES) begin
                $display("timeout: tlps_tx_ready stayed low for %0d cycles", wait_cnt);
                timeouts++;
                abort = 1'b1;
            end
        end
        tlps_tx_valid = 1'b0;
        if ($urandom_range(3) == 0) begin
            next_cycle();
        end
    endtask

    task automatic drive_tx_ready();
        while (!stim_done) begin
            tx_ready = ($urandom_range(3) != 0);
            next_cycle();
        end
        tx_ready = 1'b1;
    endtask

    task automatic drive_link();
        int hold;
        // long enough with link down to see the blink bit toggle
        repeat (80) next_cycle();
        while (!stim_done) begin
            link_up = !link_up;
            hold    = 8 + $urandom_range(40);
            repeat (hold) next_cycle();
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        void'($urandom(90242));
        clk_pcie        = 1'b0;
        rst             = 1'b1;
        rx_data         = '0;
        rx_user         = '0;
        rx_valid        = 1'b0;
        tlps_tx_data    = '0;
        tlps_tx_keep_dw = '0;
        tlps_tx_last    = 1'b0;
        tlps_tx_valid   = 1'b0;
        tx_ready        = 1'b0;
        link_up         = 1'b0;
        stim_done       = 1'b0;
        abort           = 1'b0;
        timeouts        = 0;
        repeat (4) @(posedge clk_pcie);
        #1;
        rst = 1'b0;
        next_cycle();

        fork
            begin
                fork
                    for (int t = 0; t < NUM_TLPS && !abort; t++) send_rx_tlp();
                    for (int t = 0; t < NUM_TX_BEATS && !abort; t++) send_tx_beat();
                join
                stim_done = 1'b1;
            end
            drive_tx_ready();
            drive_link();
        join

        // let the skid entry and any receive tail drain
        waited = 0;
        while (u_tlp_checker.pending_beats() != 0 && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (u_tlp_checker.pending_beats() != 0) begin
            $display("timeout: %0d expected beats never left the DUT",
                     u_tlp_checker.pending_beats());
            timeouts++;
        end
        repeat (4) next_cycle();

        u_tlp_checker.print_summary(timeouts);
        if (u_tlp_checker.error_total() == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: build.f
design/tlp_stream_pkg.sv
design/rx_tlp_realign.sv
design/tx_tlp_skid.sv
design/link_led_blink.sv
design/pcie_tlp_adapter.sv
dv/tlp_checker.sv
dv/tb_pcie_tlp_adapter.sv

// File: run.sh
#!/bin/sh
# compile and run the adapter testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f build.f \
    --top-module tb_pcie_tlp_adapter \
    -Mdir obj_dir

./obj_dir/Vtb_pcie_tlp_adapter > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished, log in sim.log"
